//--- vlog.f
logic/rv_isa_pkg.sv
logic/decode_pkg.sv
logic/decode_if.sv
logic/field_extract.sv
logic/op_classify.sv
logic/decode_pipe_reg.sv
logic/decode_top.sv
test/tb_decode.sv

//--- run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module tb_decode -Mdir obj_dir -o tb_decode
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_decode)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

//--- test/tb_decode.sv
module tb_decode;
    import rv_isa_pkg::*;
    import decode_pkg::*;

    localparam int clk_period   = 40;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 5;
    // about fifty instructions at three to four cycles each
    localparam int test_cycles   = 200;
    localparam int watchdog_time = (reset_cycles + test_cycles) * clk_period + 50 * clk_period;

    logic                      d_clk;
    logic                      d_rst;
    logic [xlen-1:0]           d_i_instr;
    logic [31:0]               d_i_pc;
    logic                      d_i_ce;
    logic                      d_i_stall;
    logic                      d_i_flush;
    logic [31:0]               d_o_pc;
    logic [reg_addr_width-1:0] d_o_addr_rs1;
    logic [reg_addr_width-1:0] d_o_addr_rs2;
    logic [reg_addr_width-1:0] d_o_addr_rd;
    logic [funct3_width-1:0]   d_o_funct3;
    logic [xlen-1:0]           d_o_imm;
    logic [alu_width-1:0]      d_o_alu;
    logic [op_class_width-1:0] d_o_opcode;
    logic [exc_width-1:0]      d_o_exception;
    logic                      d_o_ce;
    logic                      d_o_stall;
    logic                      d_o_flush;

    integer seed = 32'hea46a840;
    int checks = 0;
    int errors = 0;
    logic [31:0] last_pc;

    decode_top #(.pc_width(32)) i_dut (.*);

    always #(clk_period / 2) d_clk = ~d_clk;

    task automatic check_addr(input string name, input logic [reg_addr_width-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_funct3(input string name, input logic [funct3_width-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_alu(input string name, input logic [alu_width-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input logic [op_class_width-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_exc(input string name, input logic [exc_width-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, rand_reg(), rand_reg(), f3, rand_reg(), opcode_rtype};
    endfunction

    function automatic logic [exc_width-1:0] exc_bit(input int idx);
        logic [exc_width-1:0] v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    // immediate as the base ISA lays it out, bit by bit from the raw word
    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        case (w[6:0])
            opcode_itype, opcode_load, opcode_jalr: return {{20{w[31]}}, w[31:20]};
            opcode_store:  return {{20{w[31]}}, w[31:25], w[11:7]};
            opcode_branch: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            opcode_jal:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            opcode_lui, opcode_auipc:   return {w[31:12], 12'd0};
            opcode_system, opcode_fence: return {20'd0, w[31:20]};
            default: return '0;
        endcase
    endfunction

    function automatic logic [alu_width-1:0] ref_alu(input logic [31:0] w);
        logic [alu_width-1:0] v;
        logic [2:0] f3;
        v = '0;
        f3 = w[14:12];
        if (w[6:0] == opcode_rtype || w[6:0] == opcode_itype) begin
            case (f3)
                funct3_add:  v[(w[6:0] == opcode_rtype && w[30]) ? alu_sub : alu_add] = 1'b1;
                funct3_sll:  v[alu_sll] = 1'b1;
                funct3_slt:  v[alu_slt] = 1'b1;
                funct3_sltu: v[alu_sltu] = 1'b1;
                funct3_xor:  v[alu_xor] = 1'b1;
                funct3_sr:   v[w[30] ? alu_sra : alu_srl] = 1'b1;
                funct3_or:   v[alu_or] = 1'b1;
                default:     v[alu_and] = 1'b1;
            endcase
        end else if (w[6:0] == opcode_branch) begin
            case (f3)
                funct3_beq:  v[alu_eq] = 1'b1;
                funct3_bne:  v[alu_neq] = 1'b1;
                funct3_blt:  v[alu_lt] = 1'b1;
                funct3_bge:  v[alu_ge] = 1'b1;
                funct3_bltu: v[alu_ltu] = 1'b1;
                default:     v[alu_geu] = 1'b1;
            endcase
        end else begin
            v[alu_add] = 1'b1;
        end
        return v;
    endfunction

    function automatic logic [op_class_width-1:0] ref_class(input logic [6:0] op);
        logic [op_class_width-1:0] v;
        v = '0;
        case (op)
            opcode_rtype:  v[cls_rtype] = 1'b1;
            opcode_itype:  v[cls_itype] = 1'b1;
            opcode_load:   v[cls_load] = 1'b1;
            opcode_store:  v[cls_store] = 1'b1;
            opcode_branch: v[cls_branch] = 1'b1;
            opcode_jal:    v[cls_jal] = 1'b1;
            opcode_jalr:   v[cls_jalr] = 1'b1;
            opcode_lui:    v[cls_lui] = 1'b1;
            opcode_auipc:  v[cls_auipc] = 1'b1;
            opcode_system: v[cls_system] = 1'b1;
            opcode_fence:  v[cls_fence] = 1'b1;
            default: ;
        endcase
        return v;
    endfunction

    // one accepted instruction, sampled at the falling edge after capture
    task automatic apply_instr(input logic [31:0] w);
        @(posedge d_clk);
        #drive_delay;
        d_i_instr = w;
        d_i_pc = rand_word();
        last_pc = d_i_pc;
        d_i_ce = 1'b1;
        @(posedge d_clk);
        #drive_delay;
        d_i_ce = 1'b0;
        @(negedge d_clk);
    endtask

    task automatic check_decode(input string name, input logic [31:0] w,
                                input logic [exc_width-1:0] exc);
        logic [6:0] op;
        logic use_rs1;
        logic use_rs2;
        logic use_rd;
        logic zero_f3;
        op = w[6:0];
        use_rs2 = op inside {opcode_rtype, opcode_store, opcode_branch};
        use_rs1 = use_rs2 || (op inside {opcode_itype, opcode_load, opcode_jalr,
                                         opcode_system, opcode_fence});
        use_rd = !(op inside {opcode_store, opcode_branch});
        zero_f3 = op inside {opcode_lui, opcode_auipc, opcode_jal};
        check_addr($sformatf("%s rs1", name), use_rs1 ? w[19:15] : 5'd0, d_o_addr_rs1);
        check_addr($sformatf("%s rs2", name), use_rs2 ? w[24:20] : 5'd0, d_o_addr_rs2);
        check_addr($sformatf("%s rd", name), use_rd ? w[11:7] : 5'd0, d_o_addr_rd);
        check_funct3($sformatf("%s funct3", name), zero_f3 ? 3'd0 : w[14:12], d_o_funct3);
        check_word($sformatf("%s imm", name), ref_imm(w), d_o_imm);
        check_word($sformatf("%s pc", name), last_pc, d_o_pc);
        check_alu($sformatf("%s alu", name), ref_alu(w), d_o_alu);
        check_class($sformatf("%s class", name), ref_class(op), d_o_opcode);
        check_exc($sformatf("%s exception", name), exc, d_o_exception);
    endtask

    task automatic run_legal(input string name, input logic [31:0] w);
        apply_instr(w);
        check_decode(name, w, '0);
    endtask

    task automatic run_random(input string name, input logic [6:0] op, input logic [2:0] f3);
        logic [31:0] w;
        w = rand_word();
        w[6:0] = op;
        w[14:12] = f3;
        run_legal(name, w);
    endtask

    task automatic test_alu_decode();
        logic [31:0] imm_bits;
        logic [2:0] f3v;
        for (int f3 = 0; f3 < 8; f3++) begin
            f3v = f3[2:0];
            run_legal($sformatf("rtype f3=%0d", f3), enc_r(funct7_zero, f3v));
        end
        run_legal("rtype sub", enc_r(funct7_alt, funct3_add));
        run_legal("rtype sra", enc_r(funct7_alt, funct3_sr));
        for (int f3 = 0; f3 < 8; f3++) begin
            f3v = f3[2:0];
            imm_bits = rand_word();
            // shifts carry a shift amount with a zero funct7 field
            if (f3v == funct3_sll || f3v == funct3_sr) begin
                imm_bits[11:5] = funct7_zero;
            end
            run_legal($sformatf("itype f3=%0d", f3),
                      {imm_bits[11:0], rand_reg(), f3v, rand_reg(), opcode_itype});
        end
        imm_bits = rand_word();
        run_legal("itype sra",
                  {funct7_alt, imm_bits[4:0], rand_reg(), funct3_sr, rand_reg(), opcode_itype});
    endtask

    task automatic test_immediates();
        run_random("imm itype", opcode_itype, funct3_add);
        run_random("imm load", opcode_load, funct3_lw);
        run_random("imm jalr", opcode_jalr, 3'd0);
        run_random("imm store", opcode_store, funct3_sw);
        run_random("imm branch", opcode_branch, funct3_beq);
        run_random("imm jal", opcode_jal, 3'd0);
        run_random("imm lui", opcode_lui, 3'd0);
        run_random("imm auipc", opcode_auipc, 3'd0);
        run_random("imm system", opcode_system, 3'd1);
        run_random("imm fence", opcode_fence, 3'd0);
    endtask

    task automatic run_syscall(input string name, input logic [11:0] sys, input int idx,
                               input logic flush);
        logic [31:0] w;
        w = {sys, 5'd0, 3'd0, 5'd0, opcode_system};
        apply_instr(w);
        check_decode(name, w, exc_bit(idx));
        check_flag($sformatf("%s flush", name), flush, d_o_flush);
        @(negedge d_clk);
        check_exc($sformatf("%s cleared", name), '0, d_o_exception);
        check_flag($sformatf("%s flush cleared", name), 1'b0, d_o_flush);
    endtask

    task automatic test_system_calls();
        run_syscall("ecall", sys_ecall, exc_ecall, 1'b1);
        run_syscall("ebreak", sys_ebreak, exc_ebreak, 1'b0);
        run_syscall("mret", sys_mret, exc_mret, 1'b0);
    endtask

    task automatic run_illegal(input string name, input logic [31:0] w);
        @(posedge d_clk);
        #drive_delay;
        d_i_instr = w;
        d_i_pc = rand_word();
        last_pc = d_i_pc;
        d_i_ce = 1'b1;
        @(posedge d_clk);
        #drive_delay;
        // a legal follower with ce still high must wait out the one-cycle stall
        d_i_instr = enc_r(funct7_zero, funct3_or);
        d_i_pc = rand_word();
        @(negedge d_clk);
        check_exc(name, exc_bit(exc_illegal), d_o_exception);
        check_flag($sformatf("%s ce", name), 1'b1, d_o_ce);
        check_flag($sformatf("%s stall", name), 1'b1, d_o_stall);
        @(posedge d_clk);
        #drive_delay;
        d_i_ce = 1'b0;
        @(negedge d_clk);
        check_flag($sformatf("%s stall released", name), 1'b0, d_o_stall);
        check_flag($sformatf("%s ce dropped", name), 1'b0, d_o_ce);
        check_exc($sformatf("%s cleared", name), '0, d_o_exception);
        check_word($sformatf("%s pc held", name), last_pc, d_o_pc);
    endtask

    task automatic test_illegal();
        logic [31:0] w;
        w = rand_word();
        w[6:0] = 7'b1111111;
        run_illegal("illegal opcode", w);
        run_illegal("illegal funct7", enc_r(7'b0000001, funct3_add));
        run_illegal("illegal load",
                    (rand_word() & 32'hffff_8f80) | 32'h0000_3000 | {25'd0, opcode_load});
        run_illegal("illegal store",
                    (rand_word() & 32'hffff_8f80) | 32'h0000_3000 | {25'd0, opcode_store});
        run_illegal("illegal fence", {17'd0, 3'd2, 5'd0, opcode_fence});
    endtask

    task automatic test_stall_flush();
        logic [31:0] a;
        logic [31:0] b;
        a = enc_r(funct7_zero, funct3_xor);
        b = enc_r(funct7_alt, funct3_add);
        @(posedge d_clk);
        #drive_delay;
        d_i_instr = a;
        d_i_pc = rand_word();
        last_pc = d_i_pc;
        d_i_ce = 1'b1;
        @(posedge d_clk);
        #drive_delay;
        d_i_instr = b;
        d_i_pc = rand_word();
        d_i_stall = 1'b1;
        @(negedge d_clk);
        check_decode("stall hold", a, '0);
        check_flag("stall ce", 1'b1, d_o_ce);
        check_flag("stall out", 1'b1, d_o_stall);
        @(posedge d_clk);
        #drive_delay;
        d_i_ce = 1'b0;
        @(negedge d_clk);
        check_decode("stall hold", a, '0);
        check_flag("stall ce", 1'b1, d_o_ce);
        check_flag("stall out", 1'b1, d_o_stall);
        // ce_q keeps its value under the external stall even with d_i_ce low
        @(posedge d_clk);
        #drive_delay;
        d_i_stall = 1'b0;
        @(negedge d_clk);
        check_flag("stall ce held", 1'b1, d_o_ce);
        check_flag("stall released", 1'b0, d_o_stall);
        @(negedge d_clk);
        check_decode("after stall", a, '0);
        check_flag("after stall ce", 1'b0, d_o_ce);

        @(posedge d_clk);
        #drive_delay;
        d_i_pc = rand_word();
        last_pc = d_i_pc;
        d_i_ce = 1'b1;
        d_i_flush = 1'b1;
        @(negedge d_clk);
        check_flag("flush echo", 1'b1, d_o_flush);
        @(negedge d_clk);
        check_decode("flush capture", b, '0);
        check_flag("flush ce", 1'b0, d_o_ce);
        @(posedge d_clk);
        #drive_delay;
        d_i_flush = 1'b0;
        d_i_ce = 1'b0;
        @(negedge d_clk);
        check_flag("flush released", 1'b0, d_o_flush);
    endtask

    task automatic test_branches();
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) begin
                continue;
            end
            run_random($sformatf("branch f3=%0d", f3), opcode_branch, f3[2:0]);
        end
    endtask

    initial begin
        #watchdog_time;
        $display("timeout: tests did not complete within %0d time units", watchdog_time);
        $display("Errors found");
        $finish;
    end

    initial begin
        d_clk = 1'b0;
        d_rst = 1'b0;
        d_i_instr = '0;
        d_i_pc = '0;
        d_i_ce = 1'b0;
        d_i_stall = 1'b0;
        d_i_flush = 1'b0;
        last_pc = '0;
        repeat (reset_cycles) @(posedge d_clk);
        #drive_delay;
        d_rst = 1'b1;

        test_alu_decode();
        test_immediates();
        test_system_calls();
        test_illegal();
        test_stall_flush();
        test_branches();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- logic/decode_top.sv
module decode_top #(
    parameter int pc_width = 32
) (
    input  logic                                    d_clk,
    input  logic                                    d_rst,
    input  logic [rv_isa_pkg::xlen-1:0]             d_i_instr,
    input  logic [pc_width-1:0]                     d_i_pc,
    input  logic                                    d_i_ce,
    input  logic                                    d_i_stall,
    input  logic                                    d_i_flush,
    output logic [pc_width-1:0]                     d_o_pc,
    output logic [rv_isa_pkg::reg_addr_width-1:0]   d_o_addr_rs1,
    output logic [rv_isa_pkg::reg_addr_width-1:0]   d_o_addr_rs2,
    output logic [rv_isa_pkg::reg_addr_width-1:0]   d_o_addr_rd,
    output logic [rv_isa_pkg::funct3_width-1:0]     d_o_funct3,
    output logic [rv_isa_pkg::xlen-1:0]             d_o_imm,
    output logic [decode_pkg::alu_width-1:0]        d_o_alu,
    output logic [decode_pkg::op_class_width-1:0]   d_o_opcode,
    output logic [decode_pkg::exc_width-1:0]        d_o_exception,
    output logic                                    d_o_ce,
    output logic                                    d_o_stall,
    output logic                                    d_o_flush
);

    decode_if dec_bus ();

    field_extract u_field_extract (
        .instr (d_i_instr),
        .dec   (dec_bus.fields_src)
    );

    op_classify u_op_classify (
        .instr (d_i_instr),
        .dec   (dec_bus.class_src)
    );

    decode_pipe_reg #(
        .pc_width (pc_width)
    ) u_decode_pipe_reg (
        .d_clk      (d_clk),
        .d_rst      (d_rst),
        .pc         (d_i_pc),
        .ce         (d_i_ce),
        .stall_in   (d_i_stall),
        .flush_in   (d_i_flush),
        .dec        (dec_bus.sink),
        .pc_q       (d_o_pc),
        .rs1_q      (d_o_addr_rs1),
        .rs2_q      (d_o_addr_rs2),
        .rd_q       (d_o_addr_rd),
        .funct3_q   (d_o_funct3),
        .imm_q      (d_o_imm),
        .alu_q      (d_o_alu),
        .op_class_q (d_o_opcode),
        .exc_q      (d_o_exception),
        .ce_q       (d_o_ce),
        .stall_out  (d_o_stall),
        .flush_out  (d_o_flush)
    );

endmodule

//--- logic/decode_pipe_reg.sv
module decode_pipe_reg #(
    parameter int pc_width = 32
) (
    input  logic                                    d_clk,
    input  logic                                    d_rst,
    input  logic [pc_width-1:0]                     pc,
    input  logic                                    ce,
    input  logic                                    stall_in,
    input  logic                                    flush_in,
    decode_if.sink                                  dec,
    output logic [pc_width-1:0]                     pc_q,
    output logic [rv_isa_pkg::reg_addr_width-1:0]   rs1_q,
    output logic [rv_isa_pkg::reg_addr_width-1:0]   rs2_q,
    output logic [rv_isa_pkg::reg_addr_width-1:0]   rd_q,
    output logic [rv_isa_pkg::funct3_width-1:0]     funct3_q,
    output logic [rv_isa_pkg::xlen-1:0]             imm_q,
    output logic [decode_pkg::alu_width-1:0]        alu_q,
    output logic [decode_pkg::op_class_width-1:0]   op_class_q,
    output logic [decode_pkg::exc_width-1:0]        exc_q,
    output logic                                    ce_q,
    output logic                                    stall_out,
    output logic                                    flush_out
);
    import decode_pkg::*;

    logic stall;
    logic capture;

    // an illegal instruction holds the stage for one cycle, then ce_q drops
    assign stall_out = stall_in || (exc_q[exc_illegal] && ce_q);
    assign flush_out = flush_in || exc_q[exc_ecall];
    assign stall     = stall_in || stall_out;
    assign capture   = ce && !stall;

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            pc_q       <= '0;
            rs1_q      <= '0;
            rs2_q      <= '0;
            rd_q       <= '0;
            alu_q      <= '0;
            op_class_q <= '0;
            exc_q      <= '0;
            ce_q       <= 1'b0;
        end else begin
            if (capture) begin
                pc_q                <= pc;
                rs1_q               <= dec.rs1;
                rs2_q               <= dec.rs2;
                rd_q                <= dec.rd;
                alu_q               <= dec.alu;
                op_class_q          <= dec.op_class;
                exc_q[exc_illegal]  <= dec.illegal;
                exc_q[exc_ecall]    <= dec.ecall;
                exc_q[exc_ebreak]   <= dec.ebreak;
                exc_q[exc_mret]     <= dec.mret;
            end else begin
                exc_q <= '0;
            end

            if (flush_in && !stall) begin
                ce_q <= 1'b0;
            end else if (!stall) begin
                ce_q <= ce;
            end else if (!stall_in) begin
                // stalled only by our own illegal instruction
                ce_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge d_clk) begin
        if (capture) begin
            funct3_q <= dec.funct3;
            imm_q    <= dec.imm;
        end
    end

endmodule

//--- logic/op_classify.sv
module op_classify (
    input rv_isa_pkg::instr_word_u instr,
    decode_if.class_src            dec
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] sys_imm;

    // ALU bit for a funct3 when funct7 is zero
    function automatic int alu_index(input logic [2:0] f3);
        case (f3)
            funct3_add:  return alu_add;
            funct3_sll:  return alu_sll;
            funct3_slt:  return alu_slt;
            funct3_sltu: return alu_sltu;
            funct3_xor:  return alu_xor;
            funct3_sr:   return alu_srl;
            funct3_or:   return alu_or;
            default:     return alu_and;
        endcase
    endfunction

    assign opcode  = instr.r_fmt.opcode;
    assign funct3  = instr.r_fmt.funct3;
    assign funct7  = instr.r_fmt.funct7;
    assign sys_imm = instr.i_fmt.imm;

    always_comb begin
        dec.op_class = '0;
        dec.alu      = '0;
        dec.illegal  = 1'b0;
        dec.ecall    = 1'b0;
        dec.ebreak   = 1'b0;
        dec.mret     = 1'b0;
        case (opcode)
            opcode_rtype: begin
                dec.op_class[cls_rtype] = 1'b1;
                if (funct7 == funct7_zero) begin
                    dec.alu[alu_index(funct3)] = 1'b1;
                end else if (funct7 == funct7_alt && funct3 == funct3_add) begin
                    dec.alu[alu_sub] = 1'b1;
                end else if (funct7 == funct7_alt && funct3 == funct3_sr) begin
                    dec.alu[alu_sra] = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            opcode_itype: begin
                dec.op_class[cls_itype] = 1'b1;
                // only shifts carry funct7, and bit 25 must be clear there
                if (funct3 == funct3_sr && funct7 == funct7_alt) begin
                    dec.alu[alu_sra] = 1'b1;
                end else if ((funct3 == funct3_sll || funct3 == funct3_sr) &&
                             funct7 != funct7_zero) begin
                    dec.illegal = 1'b1;
                end else begin
                    dec.alu[alu_index(funct3)] = 1'b1;
                end
            end
            opcode_branch: begin
                dec.op_class[cls_branch] = 1'b1;
                case (funct3)
                    funct3_beq:  dec.alu[alu_eq]  = 1'b1;
                    funct3_bne:  dec.alu[alu_neq] = 1'b1;
                    funct3_blt:  dec.alu[alu_lt]  = 1'b1;
                    funct3_bge:  dec.alu[alu_ge]  = 1'b1;
                    funct3_bltu: dec.alu[alu_ltu] = 1'b1;
                    funct3_bgeu: dec.alu[alu_geu] = 1'b1;
                    default:     dec.illegal      = 1'b1;
                endcase
            end
            opcode_load: begin
                dec.op_class[cls_load] = 1'b1;
                dec.alu[alu_add] = 1'b1;
                dec.illegal = !(funct3 inside {funct3_lb, funct3_lh, funct3_lw,
                                               funct3_lbu, funct3_lhu});
            end
            opcode_store: begin
                dec.op_class[cls_store] = 1'b1;
                dec.alu[alu_add] = 1'b1;
                dec.illegal = !(funct3 inside {funct3_sb, funct3_sh, funct3_sw});
            end
            opcode_fence: begin
                dec.op_class[cls_fence] = 1'b1;
                dec.alu[alu_add] = 1'b1;
                dec.illegal = (funct3 > 3'd1);
            end
            opcode_system: begin
                dec.op_class[cls_system] = 1'b1;
                dec.alu[alu_add] = 1'b1;
                if (funct3 == 3'd0) begin
                    dec.ecall  = (sys_imm == sys_ecall);
                    dec.ebreak = (sys_imm == sys_ebreak);
                    dec.mret   = (sys_imm == sys_mret);
                end
            end
            opcode_jal: begin
                dec.op_class[cls_jal] = 1'b1;
                dec.alu[alu_add] = 1'b1;
            end
            opcode_jalr: begin
                dec.op_class[cls_jalr] = 1'b1;
                dec.alu[alu_add] = 1'b1;
            end
            opcode_lui: begin
                dec.op_class[cls_lui] = 1'b1;
                dec.alu[alu_add] = 1'b1;
            end
            opcode_auipc: begin
                dec.op_class[cls_auipc] = 1'b1;
                dec.alu[alu_add] = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

//--- logic/field_extract.sv
module field_extract (
    input rv_isa_pkg::instr_word_u instr,
    decode_if.fields_src           dec
);
    import rv_isa_pkg::*;

    // unused register addresses and funct3 stay zero for the execute stage
    always_comb begin
        dec.rs1    = '0;
        dec.rs2    = '0;
        dec.rd     = '0;
        dec.funct3 = '0;
        dec.imm    = '0;
        case (instr.r_fmt.opcode)
            opcode_rtype: begin
                dec.rs1    = instr.r_fmt.rs1;
                dec.rs2    = instr.r_fmt.rs2;
                dec.rd     = instr.r_fmt.rd;
                dec.funct3 = instr.r_fmt.funct3;
            end
            opcode_itype, opcode_load, opcode_jalr: begin
                dec.rs1    = instr.i_fmt.rs1;
                dec.rd     = instr.i_fmt.rd;
                dec.funct3 = instr.i_fmt.funct3;
                dec.imm    = {{(xlen-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            opcode_system, opcode_fence: begin
                dec.rs1    = instr.i_fmt.rs1;
                dec.rd     = instr.i_fmt.rd;
                dec.funct3 = instr.i_fmt.funct3;
                dec.imm    = {{(xlen-12){1'b0}}, instr.i_fmt.imm};
            end
            opcode_store: begin
                dec.rs1    = instr.s_fmt.rs1;
                dec.rs2    = instr.s_fmt.rs2;
                dec.funct3 = instr.s_fmt.funct3;
                dec.imm    = {{(xlen-12){instr.s_fmt.imm_hi[6]}},
                              instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            end
            opcode_branch: begin
                dec.rs1    = instr.b_fmt.rs1;
                dec.rs2    = instr.b_fmt.rs2;
                dec.funct3 = instr.b_fmt.funct3;
                dec.imm    = {{(xlen-12){instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                              instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            opcode_jal: begin
                dec.rd  = instr.j_fmt.rd;
                dec.imm = {{(xlen-20){instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                           instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            end
            opcode_lui, opcode_auipc: begin
                dec.rd  = instr.u_fmt.rd;
                dec.imm = {instr.u_fmt.imm, {(xlen-20){1'b0}}};
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/decode_if.sv
interface decode_if;
    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [funct3_width-1:0]   funct3;
    logic [xlen-1:0]           imm;

    logic [alu_width-1:0]      alu;
    logic [op_class_width-1:0] op_class;
    logic                      illegal;
    logic                      ecall;
    logic                      ebreak;
    logic                      mret;

    modport fields_src (
        output rs1, rs2, rd, funct3, imm
    );

    modport class_src (
        output alu, op_class, illegal, ecall, ebreak, mret
    );

    modport sink (
        input rs1, rs2, rd, funct3, imm,
        input alu, op_class, illegal, ecall, ebreak, mret
    );

endinterface

//--- logic/decode_pkg.sv
package decode_pkg;

    // one-hot ALU operation vector
    localparam int alu_width = 16;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_xor  = 4;
    localparam int alu_or   = 5;
    localparam int alu_and  = 6;
    localparam int alu_sll  = 7;
    localparam int alu_srl  = 8;
    localparam int alu_sra  = 9;
    localparam int alu_eq   = 10;
    localparam int alu_neq  = 11;
    localparam int alu_lt   = 12;
    localparam int alu_ltu  = 13;
    localparam int alu_ge   = 14;
    localparam int alu_geu  = 15;

    // one-hot opcode class vector
    localparam int op_class_width = 11;
    localparam int cls_rtype  = 0;
    localparam int cls_itype  = 1;
    localparam int cls_load   = 2;
    localparam int cls_store  = 3;
    localparam int cls_branch = 4;
    localparam int cls_jal    = 5;
    localparam int cls_jalr   = 6;
    localparam int cls_lui    = 7;
    localparam int cls_auipc  = 8;
    localparam int cls_system = 9;
    localparam int cls_fence  = 10;

    localparam int exc_width   = 4;
    localparam int exc_illegal = 0;
    localparam int exc_ecall   = 1;
    localparam int exc_ebreak  = 2;
    localparam int exc_mret    = 3;

endpackage

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int funct3_width = 3;

    localparam logic [6:0] opcode_rtype  = 7'b0110011;
    localparam logic [6:0] opcode_itype  = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_system = 7'b1110011;
    localparam logic [6:0] opcode_fence  = 7'b0001111;

    // ALU funct3, shared by R-type and I-type
    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_sll  = 3'b001;
    localparam logic [2:0] funct3_slt  = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor  = 3'b100;
    localparam logic [2:0] funct3_sr   = 3'b101;
    localparam logic [2:0] funct3_or   = 3'b110;
    localparam logic [2:0] funct3_and  = 3'b111;

    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;

    localparam logic [2:0] funct3_sb = 3'b000;
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;

    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    localparam logic [6:0] funct7_zero = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    localparam logic [11:0] sys_ecall  = 12'h000;
    localparam logic [11:0] sys_ebreak = 12'h001;
    localparam logic [11:0] sys_mret   = 12'h302;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_word_u;

endpackage
